// File: logic/dbg_i2c_pkg.sv
// Bus-side definitions for the I2C debug slave, imported by the engine, controller and top
package dbg_i2c_pkg;

  // One byte as it travels on SDA
  typedef logic [7:0] i2c_byte_t;

  // 7-bit slave address, R/W bit not included
  typedef logic [6:0] i2c_dev_addr_t;

  // Bus FSM
  typedef enum logic [2:0] {
    // Address byte coming in
    rx_addr     = 3'h0,
    // Slave pulls SDA low for the address
    rx_addr_ack = 3'h1,
    rx_data     = 3'h2,
    rx_data_ack = 3'h3,
    tx_data     = 3'h4,
    // Master answers ACK or NACK
    tx_data_ack = 3'h5
  } i2c_state_e;

endpackage

// File: logic/dbg_reg_pkg.sv
// Debug-register-side definitions, imported by the command controller and top
package dbg_reg_pkg;

  // Debug register address, 64 registers
  typedef logic [5:0] dbg_addr_t;

  // Debug register data word
  typedef logic [15:0] dbg_data_t;

  // Command byte as the master sends it
  typedef struct packed {
    // Set for write, clear for read
    logic      write;
    // Set for 8-bit access, clear for 16-bit
    logic      byte_width;
    dbg_addr_t addr;
  } dbg_cmd_t;

  // Command FSM
  typedef enum logic [2:0] {
    rx_cmd     = 3'h0,
    rx_byte_lo = 3'h1,
    rx_byte_hi = 3'h2,
    // Read data going back to the master
    tx_byte_lo = 3'h3,
    tx_byte_hi = 3'h4
  } dbg_state_e;

endpackage

// File: logic/dbg_byte_if.sv
// Byte handoff between the I2C byte engine and the debug command controller
interface dbg_byte_if import dbg_i2c_pkg::*; ();

  // One-cycle strobe per received data byte, never for address bytes
  logic      rx_data_done;

  // One-cycle strobe once the last bit of a sent byte is out
  logic      tx_data_done;

  // Valid while rx_data_done is high
  i2c_byte_t rx_byte;

  // Next byte to send, sampled by the engine on SCL rise
  i2c_byte_t tx_byte;

  modport engine (
    output rx_data_done,
    output tx_data_done,
    output rx_byte,
    input  tx_byte
  );

  modport ctrl (
    input  rx_data_done,
    input  tx_data_done,
    input  rx_byte,
    output tx_byte
  );

endinterface

// File: logic/i2c_line_filter.sv
// Conditions one I2C line: synchronizer, majority vote and edge pulses for the engine
module i2c_line_filter #(
  parameter int SYNC_STAGES = 2
) (
  input  logic dbg_clk,
  input  logic dbg_rst,
  input  logic line_in,
  output logic level,
  output logic rise,
  output logic fall
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic [1:0]             hist_q;
  logic                   sync_out;
  logic                   level_dly;

  // Idle bus is high, so reset everything to one
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sync_q <= '1;
      hist_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], line_in};
      hist_q <= {hist_q[0], sync_out};
    end
  end

  assign sync_out = sync_q[SYNC_STAGES-1];

  // Two of three votes, drops single-cycle glitches
  assign level = (sync_out & hist_q[0]) | (sync_out & hist_q[1]) | (hist_q[0] & hist_q[1]);

  // Edge detect on filtered level
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      level_dly <= 1'b1;
    end else begin
      level_dly <= level;
    end
  end

  assign rise = ~level_dly & level;
  assign fall = level_dly & ~level;

endmodule

// File: logic/i2c_byte_engine.sv
// I2C slave byte engine with START/STOP, address match, byte shifting and SDA drive
module i2c_byte_engine import dbg_i2c_pkg::*; (
  input  logic          dbg_clk,
  input  logic          dbg_rst,
  input  i2c_dev_addr_t dev_addr,
  input  logic          scl,
  input  logic          scl_rise,
  input  logic          scl_fall,
  input  logic          sda,
  input  logic          sda_rise,
  input  logic          sda_fall,
  output logic          sda_out,
  dbg_byte_if.engine    bytes
);

  i2c_state_e state;
  i2c_state_e state_nxt;
  logic [8:0] shift_buf;
  logic [1:0] sample_dly;
  logic       sample;
  logic       start_det;
  logic       stop_det;
  logic       active_q;
  logic       init;
  logic       addr_miss;
  logic       rx_en;
  logic       tx_en_nxt;
  logic       rx_done;
  logic       tx_done;
  logic       rx_init;
  logic       tx_init;
  logic       rx_shift;
  logic       tx_shift;

  ////////////////////////////////////////
  // Bus conditions
  ////////////////////////////////////////

  // SDA moves while SCL is high
  assign start_det = sda_fall & scl;
  assign stop_det  = sda_rise & scl;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      active_q <= 1'b0;
    end else if (start_det) begin
      active_q <= 1'b1;
    end else if (stop_det || addr_miss) begin
      active_q <= 1'b0;
    end
  end

  // Idle or fresh START returns to address
  assign init = ~active_q | stop_det | start_det;

  // SDA sampled two cycles into SCL high
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sample_dly <= 2'b00;
    end else begin
      sample_dly <= {sample_dly[0], scl_rise};
    end
  end

  assign sample = sample_dly[1];

  ////////////////////////////////////////
  // Bus FSM
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    if (init) begin
      state_nxt = rx_addr;
    end else begin
      case (state)
        rx_addr:     if (rx_done && !addr_miss) state_nxt = rx_addr_ack;
        // R/W bit still sits in bit 0
        rx_addr_ack: if (scl_fall) state_nxt = shift_buf[0] ? tx_data : rx_data;
        rx_data:     if (rx_done) state_nxt = rx_data_ack;
        rx_data_ack: if (scl_fall) state_nxt = rx_data;
        tx_data:     if (tx_done) state_nxt = tx_data_ack;
        // NACK ends the read
        tx_data_ack: if (scl_fall) state_nxt = sda ? rx_addr : tx_data;
        default:     state_nxt = rx_addr;
      endcase
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= rx_addr;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////
  // Shift buffer
  ////////////////////////////////////////

  // Marker bit reaching bit 8 means a full byte in
  // Shift buffer at 9'h100 means all bits out
  assign rx_en     = (state == rx_addr) | (state == rx_data);
  assign tx_en_nxt = (state_nxt == tx_data);
  assign rx_done   = rx_en & scl_fall & shift_buf[8];
  assign tx_done   = (state == tx_data) & scl_fall & (shift_buf == 9'h100);

  assign rx_init  = init | ((state == rx_addr_ack) & scl_fall & ~shift_buf[0]) |
                    ((state == rx_data_ack) & scl_fall);
  assign tx_init  = ((state == rx_addr_ack) & scl_rise & shift_buf[0]) |
                    ((state == tx_data_ack) & scl_rise);
  assign rx_shift = rx_en & sample;
  assign tx_shift = tx_en_nxt & scl_fall & (shift_buf != 9'h100);

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      shift_buf <= 9'h001;
    end else if (rx_init) begin
      shift_buf <= 9'h001;
    end else if (tx_init) begin
      shift_buf <= {bytes.tx_byte, 1'b1};
    end else if (rx_shift) begin
      shift_buf <= {shift_buf[7:0], sda};
    end else if (tx_shift) begin
      shift_buf <= {shift_buf[7:0], 1'b0};
    end
  end

  // Address compare on the completed address byte
  assign addr_miss = (state == rx_addr) & rx_done & (shift_buf[7:1] != dev_addr);

  assign bytes.rx_data_done = rx_done & (state == rx_data);
  assign bytes.tx_data_done = tx_done;
  assign bytes.rx_byte      = shift_buf[7:0];

  // SDA only changes on SCL fall
  // Low for ACKs and zero data bits
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sda_out <= 1'b1;
    end else if (scl_fall) begin
      sda_out <= ~((state_nxt == rx_addr_ack) | (state_nxt == rx_data_ack) |
                   (tx_shift & ~shift_buf[8]));
    end
  end

endmodule

// File: logic/dbg_cmd_ctrl.sv
// Debug command controller: decodes command bytes, drives register strobes and read data
module dbg_cmd_ctrl import dbg_i2c_pkg::*, dbg_reg_pkg::*; (
  input  logic       dbg_clk,
  input  logic       dbg_rst,
  input  dbg_data_t  dbg_dout,
  dbg_byte_if.ctrl   bytes,
  output dbg_addr_t  dbg_addr,
  output dbg_data_t  dbg_din,
  output logic       dbg_wr,
  output logic       dbg_rd
);

  dbg_state_e state;
  dbg_state_e state_nxt;
  dbg_cmd_t   cmd;
  logic       byte_width;
  logic       cmd_valid;
  logic       lo_valid;
  logic       hi_valid;
  i2c_byte_t  din_lo;
  i2c_byte_t  din_hi;

  assign cmd = bytes.rx_byte;

  ////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////

  // 8-bit accesses skip the high byte states
  always_comb begin
    state_nxt = state;
    case (state)
      rx_cmd:     if (bytes.rx_data_done) state_nxt = cmd.write ? rx_byte_lo : tx_byte_lo;
      rx_byte_lo: if (bytes.rx_data_done) state_nxt = byte_width ? rx_cmd : rx_byte_hi;
      rx_byte_hi: if (bytes.rx_data_done) state_nxt = rx_cmd;
      tx_byte_lo: if (bytes.tx_data_done) state_nxt = byte_width ? rx_cmd : tx_byte_hi;
      tx_byte_hi: if (bytes.tx_data_done) state_nxt = rx_cmd;
      default:    state_nxt = rx_cmd;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state <= rx_cmd;
    end else begin
      state <= state_nxt;
    end
  end

  assign cmd_valid = (state == rx_cmd) & bytes.rx_data_done;
  assign lo_valid  = (state == rx_byte_lo) & bytes.rx_data_done;
  assign hi_valid  = (state == rx_byte_hi) & bytes.rx_data_done;

  // Address and width held until next command
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_addr   <= '0;
      byte_width <= 1'b0;
    end else if (cmd_valid) begin
      dbg_addr   <= cmd.addr;
      byte_width <= cmd.byte_width;
    end
  end

  // Write data, high half cleared with each new low byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      din_lo <= '0;
      din_hi <= '0;
    end else if (lo_valid) begin
      din_lo <= bytes.rx_byte;
      din_hi <= '0;
    end else if (hi_valid) begin
      din_hi <= bytes.rx_byte;
    end
  end

  assign dbg_din = {din_hi, din_lo};

  // Strobes one cycle after the deciding byte
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_wr <= 1'b0;
      dbg_rd <= 1'b0;
    end else begin
      dbg_wr <= byte_width ? lo_valid : hi_valid;
      dbg_rd <= cmd_valid & ~cmd.write;
    end
  end

  // Read data half for the engine
  assign bytes.tx_byte = (state == tx_byte_hi) ? dbg_dout[15:8] : dbg_dout[7:0];

endmodule

// File: logic/dbg_i2c_top.sv
// Top of the I2C debug port slave; instantiate with the slave address and register bus
module dbg_i2c_top import dbg_i2c_pkg::*, dbg_reg_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic          dbg_clk,
  input  logic          dbg_rst,
  input  i2c_dev_addr_t dbg_i2c_addr,
  input  logic          dbg_i2c_scl,
  input  logic          dbg_i2c_sda_in,
  output logic          dbg_i2c_sda_out,
  output dbg_addr_t     dbg_addr,
  output dbg_data_t     dbg_din,
  input  dbg_data_t     dbg_dout,
  output logic          dbg_wr,
  output logic          dbg_rd
);

  logic scl_level;
  logic scl_rise;
  logic scl_fall;
  logic sda_level;
  logic sda_rise;
  logic sda_fall;

  // Same filter depth on both lines keeps SCL and SDA aligned
  i2c_line_filter #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_scl_filter (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .line_in (dbg_i2c_scl),
    .level   (scl_level),
    .rise    (scl_rise),
    .fall    (scl_fall)
  );

  i2c_line_filter #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_sda_filter (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .line_in (dbg_i2c_sda_in),
    .level   (sda_level),
    .rise    (sda_rise),
    .fall    (sda_fall)
  );

  dbg_byte_if u_bytes ();

  i2c_byte_engine u_engine (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .dev_addr (dbg_i2c_addr),
    .scl      (scl_level),
    .scl_rise (scl_rise),
    .scl_fall (scl_fall),
    .sda      (sda_level),
    .sda_rise (sda_rise),
    .sda_fall (sda_fall),
    .sda_out  (dbg_i2c_sda_out),
    .bytes    (u_bytes.engine)
  );

  dbg_cmd_ctrl u_ctrl (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .dbg_dout (dbg_dout),
    .bytes    (u_bytes.ctrl),
    .dbg_addr (dbg_addr),
    .dbg_din  (dbg_din),
    .dbg_wr   (dbg_wr),
    .dbg_rd   (dbg_rd)
  );

endmodule

// File: verification/dbg_i2c_props.sv
// Assertions on the debug command controller strobes and FSM, bound into dbg_cmd_ctrl
module dbg_i2c_props import dbg_reg_pkg::*; (
  input logic       dbg_clk,
  input logic       dbg_rst,
  input logic       dbg_wr,
  input logic       dbg_rd,
  input dbg_state_e state
);

  // Failures so far, read by the testbench at the end
  int fail_count = 0;

  ////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////

  // Write and read never in the same cycle
  a_wr_rd_excl: assert property (@(posedge dbg_clk) disable iff (dbg_rst) !(dbg_wr && dbg_rd))
    else begin
      $error("dbg_wr and dbg_rd high in the same cycle");
      fail_count++;
    end

  // Single-cycle pulses
  a_wr_pulse: assert property (@(posedge dbg_clk) disable iff (dbg_rst) dbg_wr |=> !dbg_wr)
    else begin
      $error("dbg_wr held high for more than one cycle");
      fail_count++;
    end

  a_rd_pulse: assert property (@(posedge dbg_clk) disable iff (dbg_rst) dbg_rd |=> !dbg_rd)
    else begin
      $error("dbg_rd held high for more than one cycle");
      fail_count++;
    end

  ////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////

  a_state_legal: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    state inside {rx_cmd, rx_byte_lo, rx_byte_hi, tx_byte_lo, tx_byte_hi})
    else begin
      $error("Command FSM left its legal states");
      fail_count++;
    end

endmodule

bind dbg_cmd_ctrl dbg_i2c_props u_props (
  .dbg_clk (dbg_clk),
  .dbg_rst (dbg_rst),
  .dbg_wr  (dbg_wr),
  .dbg_rd  (dbg_rd),
  .state   (state)
);

// File: verification/dbg_i2c_tb.sv
// Testbench for the I2C debug slave: bit-banged bus master, register model and result checks
module dbg_i2c_tb import dbg_i2c_pkg::*, dbg_reg_pkg::*; ();

  // Clock cycles per SCL phase
  localparam int            HALF           = 16;
  localparam i2c_dev_addr_t DEV_ADDR       = 7'h2A;
  localparam i2c_dev_addr_t BAD_ADDR       = 7'h15;
  // Bytes on the bus over all tests, 9 SCL periods each
  localparam int            BUS_BYTES      = 23;
  localparam int            TIMEOUT_CYCLES = 2 * BUS_BYTES * 9 * 2 * HALF + 2000;

  logic        dbg_clk;
  logic        dbg_rst;
  logic        scl_m;
  logic        sda_m;
  logic        sda_line;
  logic        dbg_i2c_sda_out;
  dbg_addr_t   dbg_addr;
  dbg_data_t   dbg_din;
  dbg_data_t   dbg_dout;
  logic        dbg_wr;
  logic        dbg_rd;
  dbg_data_t   regs [64];
  logic [31:0] lfsr;
  string       test_name;
  int          error_count = 0;
  int          check_count = 0;
  int          wr_count    = 0;
  int          rd_count    = 0;
  int          cycle_count = 0;
  dbg_addr_t   exp_wr_addr [$];
  dbg_data_t   exp_wr_data [$];
  dbg_addr_t   exp_rd_addr [$];
  i2c_byte_t   exp_rd_bytes [$];
  i2c_byte_t   got_rd_bytes [$];

  // Open-drain SDA, low when either side pulls
  assign sda_line = sda_m & dbg_i2c_sda_out;
  // Register file answers combinationally
  assign dbg_dout = regs[dbg_addr];

  dbg_i2c_top #(
    .SYNC_STAGES(2)
  ) dut (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_i2c_addr    (DEV_ADDR),
    .dbg_i2c_scl     (scl_m),
    .dbg_i2c_sda_in  (sda_line),
    .dbg_i2c_sda_out (dbg_i2c_sda_out),
    .dbg_addr        (dbg_addr),
    .dbg_din         (dbg_din),
    .dbg_dout        (dbg_dout),
    .dbg_wr          (dbg_wr),
    .dbg_rd          (dbg_rd)
  );

  initial begin
    dbg_clk = 1'b0;
    forever #10 dbg_clk = ~dbg_clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Inputs move just after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge dbg_clk);
    #2;
  endtask

  // Galois LFSR, one step per bit taken
  function automatic i2c_byte_t lfsr_byte();
    i2c_byte_t value;
    logic      bit_out;
    value = '0;
    for (int i = 0; i < 8; i++) begin
      bit_out = lfsr[0];
      lfsr    = lfsr >> 1;
      if (bit_out) begin
        lfsr = lfsr ^ 32'hD000_0001;
      end
      value = {value[6:0], bit_out};
    end
    return value;
  endfunction

  // Reference: dbg_din of a write, or the word a read returns
  function automatic dbg_data_t expect_word(dbg_cmd_t cmd, i2c_byte_t lo, i2c_byte_t hi,
                                            dbg_data_t model);
    dbg_data_t word;
    word = cmd.write ? {hi, lo} : model;
    // 8-bit width has no high byte
    if (cmd.byte_width) begin
      word[15:8] = 8'h00;
    end
    return word;
  endfunction

  task automatic check_addr(input string what, input dbg_addr_t exp, input dbg_addr_t got);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, got);
    end
  endtask

  task automatic check_data(input string what, input dbg_data_t exp, input dbg_data_t got);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, got);
    end
  endtask

  task automatic check_byte(input string what, input i2c_byte_t exp, input i2c_byte_t got);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s: %s expected %h, actual %h", test_name, what, exp, got);
    end
  endtask

  task automatic check_ack(input string what, input logic exp, input logic got);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %s: %s expected %b, actual %b", test_name, what, exp, got);
    end
  endtask

  task automatic check_pulses(input string what, input int exp, input int got);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("[FAIL] %s: %s expected %0d, actual %0d", test_name, what, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////

  // SDA set while SCL low, line sampled mid SCL high
  task automatic clock_bit(input logic b, output logic seen);
    wait_cycles(4);
    sda_m = b;
    wait_cycles(HALF - 4);
    scl_m = 1'b1;
    wait_cycles(HALF / 2);
    seen = sda_line;
    wait_cycles(HALF / 2);
    scl_m = 1'b0;
  endtask

  // Also serves as repeated START
  task automatic bus_start();
    wait_cycles(4);
    sda_m = 1'b1;
    wait_cycles(HALF - 4);
    scl_m = 1'b1;
    wait_cycles(HALF / 2);
    sda_m = 1'b0;
    wait_cycles(HALF / 2);
    scl_m = 1'b0;
  endtask

  task automatic bus_stop();
    wait_cycles(4);
    sda_m = 1'b0;
    wait_cycles(HALF - 4);
    scl_m = 1'b1;
    wait_cycles(HALF / 2);
    sda_m = 1'b1;
    wait_cycles(HALF);
  endtask

  // MSB first, ack low means ACK
  task automatic write_byte(input i2c_byte_t data, output logic ack);
    logic unused;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(data[i], unused);
    end
    clock_bit(1'b1, ack);
  endtask

  task automatic read_byte(input logic nack, output i2c_byte_t data);
    logic seen;
    logic unused;
    data = '0;
    for (int i = 0; i < 8; i++) begin
      clock_bit(1'b1, seen);
      data = {data[6:0], seen};
    end
    clock_bit(nack, unused);
  endtask

  ////////////////////////////////////////
  // Transactions
  ////////////////////////////////////////

  task automatic write_reg(input dbg_cmd_t cmd, input i2c_byte_t lo, input i2c_byte_t hi);
    logic ack;
    int   wr_before;
    wr_before = wr_count;
    exp_wr_addr.push_back(cmd.addr);
    exp_wr_data.push_back(expect_word(cmd, lo, hi, '0));
    bus_start();
    write_byte({DEV_ADDR, 1'b0}, ack);
    check_ack("address ACK", 1'b0, ack);
    write_byte(cmd, ack);
    check_ack("command ACK", 1'b0, ack);
    write_byte(lo, ack);
    check_ack("low byte ACK", 1'b0, ack);
    if (!cmd.byte_width) begin
      write_byte(hi, ack);
      check_ack("high byte ACK", 1'b0, ack);
    end
    bus_stop();
    check_pulses("dbg_wr pulses", 1, wr_count - wr_before);
  endtask

  // Command write, repeated START, then read back with NACK on the last byte
  task automatic read_reg(input dbg_cmd_t cmd);
    logic      ack;
    int        rd_before;
    dbg_data_t word;
    i2c_byte_t data;
    rd_before = rd_count;
    word      = expect_word(cmd, 8'h00, 8'h00, regs[cmd.addr]);
    exp_rd_addr.push_back(cmd.addr);
    bus_start();
    write_byte({DEV_ADDR, 1'b0}, ack);
    check_ack("address ACK", 1'b0, ack);
    write_byte(cmd, ack);
    check_ack("command ACK", 1'b0, ack);
    bus_start();
    write_byte({DEV_ADDR, 1'b1}, ack);
    check_ack("read address ACK", 1'b0, ack);
    exp_rd_bytes.push_back(word[7:0]);
    read_byte(cmd.byte_width, data);
    got_rd_bytes.push_back(data);
    if (!cmd.byte_width) begin
      exp_rd_bytes.push_back(word[15:8]);
      read_byte(1'b1, data);
      got_rd_bytes.push_back(data);
    end
    bus_stop();
    check_pulses("dbg_rd pulses", 1, rd_count - rd_before);
  endtask

  // Foreign address, then bytes the slave must ignore
  task automatic wrong_addr_access();
    logic ack;
    int   wr_before;
    int   rd_before;
    wr_before = wr_count;
    rd_before = rd_count;
    bus_start();
    write_byte({BAD_ADDR, 1'b0}, ack);
    check_ack("address NACK", 1'b1, ack);
    write_byte(8'hC5, ack);
    check_ack("ignored byte NACK", 1'b1, ack);
    write_byte(lfsr_byte(), ack);
    check_ack("ignored byte NACK", 1'b1, ack);
    bus_stop();
    check_pulses("dbg_wr pulses", 0, wr_count - wr_before);
    check_pulses("dbg_rd pulses", 0, rd_count - rd_before);
  endtask

  ////////////////////////////////////////
  // Compare process and timeout
  ////////////////////////////////////////

  // Strobes are flop outputs, stable at the falling edge
  always @(negedge dbg_clk) begin
    if (!dbg_rst && dbg_wr) begin
      wr_count++;
      $display("dbg_wr addr %h data %h", dbg_addr, dbg_din);
      if (exp_wr_addr.size() == 0) begin
        error_count++;
        $display("Unexpected dbg_wr pulse during test %s", test_name);
      end else begin
        check_addr("dbg_wr address", exp_wr_addr.pop_front(), dbg_addr);
        check_data("dbg_din", exp_wr_data.pop_front(), dbg_din);
      end
    end
    if (!dbg_rst && dbg_rd) begin
      rd_count++;
      if (exp_rd_addr.size() == 0) begin
        error_count++;
        $display("Unexpected dbg_rd pulse during test %s", test_name);
      end else begin
        check_addr("dbg_rd address", exp_rd_addr.pop_front(), dbg_addr);
      end
    end
    while (exp_rd_bytes.size() > 0 && got_rd_bytes.size() > 0) begin
      check_byte("read byte", exp_rd_bytes.pop_front(), got_rd_bytes.pop_front());
    end
  end

  always @(posedge dbg_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: bus transfers still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    dbg_cmd_t cmd;
    dbg_rst   = 1'b1;
    scl_m     = 1'b1;
    sda_m     = 1'b1;
    lfsr      = 32'h3778;
    test_name = "reset";
    // Fill pattern covers every address bit
    for (int i = 0; i < 64; i++) begin
      regs[i] = {2'b11, 6'(i), ~6'(i), 2'b01};
    end
    repeat (4) @(posedge dbg_clk);
    #2;
    dbg_rst = 1'b0;
    wait_cycles(8);

    test_name = "write_16bit";
    cmd = '{write: 1'b1, byte_width: 1'b0, addr: 6'h2C};
    write_reg(cmd, lfsr_byte(), lfsr_byte());

    // High byte left over from above must be cleared
    test_name = "write_8bit";
    cmd = '{write: 1'b1, byte_width: 1'b1, addr: 6'h11};
    write_reg(cmd, lfsr_byte(), 8'hFF);

    test_name = "read_16bit";
    cmd = '{write: 1'b0, byte_width: 1'b0, addr: 6'h3A};
    read_reg(cmd);

    test_name = "read_8bit";
    cmd = '{write: 1'b0, byte_width: 1'b1, addr: 6'h07};
    read_reg(cmd);

    test_name = "wrong_address";
    wrong_addr_access();
    test_name = "after_wrong_address";
    cmd = '{write: 1'b1, byte_width: 1'b0, addr: 6'h15};
    write_reg(cmd, lfsr_byte(), lfsr_byte());

    wait_cycles(20);
    error_count += dut.u_ctrl.u_props.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, dut.u_ctrl.u_props.fail_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: dbg_i2c.f
logic/dbg_i2c_pkg.sv
logic/dbg_reg_pkg.sv
logic/dbg_byte_if.sv
logic/i2c_line_filter.sv
logic/i2c_byte_engine.sv
logic/dbg_cmd_ctrl.sv
logic/dbg_i2c_top.sv
verification/dbg_i2c_props.sv
verification/dbg_i2c_tb.sv

// File: Makefile
# Verilator build and run of the I2C debug slave testbench

VERILATOR ?= verilator
TOP       ?= dbg_i2c_tb
FILELIST  ?= dbg_i2c.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
